/* list.f */
+incdir+include
rtl/serial_pkg.sv
rtl/stream_pkg.sv
rtl/byte_fifo.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_core.sv
tb/uart_core_asserts.sv
tb/uart_core_tb.sv

/* Makefile */
# Verilator build and run for the UART controller testbench.
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= uart_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= >>> PASS

SOURCES := $(wildcard rtl/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q -x -F '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/uart_core_tb.sv */
/*
 * Directed testbench for the UART controller. Drives frames on rxd,
 * decodes frames from txd and exercises both host streams, including
 * framing errors, start glitches, receive overrun and transmit back-pressure.
 * The run stops at the first error.
 */
`include "uart_macros.svh"

module uart_core_tb import stream_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS   = `UART_OVERSAMPLE;
    localparam int FRAME_CLKS = BIT_CLKS * (2 + `UART_DATA_BITS);
    localparam int FIFO_DEPTH = 1 << `UART_FIFO_DEPTH_LOG2;
    localparam int WAIT_LIMIT = 4 * FRAME_CLKS;
    localparam int N_BURST    = FIFO_DEPTH + 2;   // Fills FIFO and output register, plus one.

    logic        clk;
    logic        resetn;
    logic        rxd;
    logic        txd;
    rx_beat_t    rx_beat;
    logic        rx_valid;
    logic        rx_ready;
    tx_beat_t    tx_beat;
    logic        tx_valid;
    logic        tx_ready;
    logic        rx_overrun;
    logic [31:0] seed;
    int          tx_stalls;

    uart_core uut (
        .clk        (clk),
        .resetn     (resetn),
        .rxd        (rxd),
        .txd        (txd),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .tx_beat    (tx_beat),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_overrun (rx_overrun)
    );

    bind uart_core uart_core_asserts u_asserts (
        .clk        (clk),
        .resetn     (resetn),
        .rx_beat    (rx_beat),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .txd        (txd),
        .tx_idle    (tx_word_ready),
        .rx_overrun (rx_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
        if (actual !== expected)
            abort_run($sformatf("MISMATCH at %0d ns: %s, expected %0h, got %0h",
                                $time, what, expected, actual));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        seed = xorshift(seed);
        b = seed[7:0];
    endtask

    // One frame on rxd, LSB first. A low stop_ok gives a framing error.
    task automatic send_serial(input logic [7:0] data, input logic stop_ok);
        rxd = 1'b0;
        repeat (BIT_CLKS) step();
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            rxd = data[i];
            repeat (BIT_CLKS) step();
        end
        rxd = stop_ok;
        repeat (BIT_CLKS) step();
        rxd = 1'b1;
    endtask

    task automatic recv_serial(output logic [7:0] data, output logic stop);
        int waited = 0;
        while (txd !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("Timed out waiting for a start bit on txd.");
            end else begin
                step();
                waited++;
            end
        end
        repeat (BIT_CLKS / 2) step();   // Middle of the start bit.
        check(32'(0), 32'(txd), "txd start bit at mid-bit");
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            repeat (BIT_CLKS) step();
            data[i] = txd;
        end
        repeat (BIT_CLKS) step();
        stop = txd;
    endtask

    task automatic pop_rx(input logic [7:0] data, input logic frame_err);
        int waited = 0;
        while (!rx_valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("Timed out waiting for rx_valid.");
            end else begin
                step();
                waited++;
            end
        end
        check(32'(data), 32'(rx_beat.data), "rx_beat data");
        check(32'(frame_err), 32'(rx_beat.frame_err), "rx_beat frame_err");
        rx_ready = 1'b1;
        step();
        rx_ready = 1'b0;
    endtask

    task automatic push_tx(input logic [7:0] data);
        int waited = 0;
        tx_beat.data = data;
        tx_valid = 1'b1;
        while (!tx_ready) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("Timed out waiting for tx_ready.");
            end else begin
                step();
                waited++;
                tx_stalls++;
            end
        end
        step();   // Transfer edge.
        tx_valid = 1'b0;
    endtask

    task automatic reset_values();
        check(32'(1), 32'(txd), "txd after reset");
        check(32'(0), 32'(rx_valid), "rx_valid after reset");
        check(32'(0), 32'(rx_overrun), "rx_overrun after reset");
        check(32'(1), 32'(tx_ready), "tx_ready after reset");
    endtask

    task automatic receive_stream();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            next_byte(b);
            send_serial(b, 1'b1);
            pop_rx(b, 1'b0);
        end
    endtask

    task automatic frame_error_glitch();
        logic [7:0] b;
        next_byte(b);
        send_serial(b, 1'b0);
        pop_rx(b, 1'b1);
        repeat (BIT_CLKS) step();
        rxd = 1'b0;
        repeat (2) step();
        rxd = 1'b1;
        repeat (2 * FRAME_CLKS) begin
            step();
            check(32'(0), 32'(rx_valid), "rx_valid after a start glitch");
        end
        next_byte(b);
        send_serial(b, 1'b1);
        pop_rx(b, 1'b0);
    endtask

    task automatic backpressure_overrun();
        logic [7:0] sent [N_BURST];
        rx_ready = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            if (i == N_BURST - 1)
                check(32'(0), 32'(rx_overrun), "rx_overrun before the last byte");
            next_byte(sent[i]);
            send_serial(sent[i], 1'b1);
        end
        check(32'(1), 32'(rx_overrun), "rx_overrun after the burst");
        for (int i = 0; i < N_BURST - 1; i++)
            pop_rx(sent[i], 1'b0);
        repeat (FRAME_CLKS) begin
            step();
            check(32'(0), 32'(rx_valid), "rx_valid after the last kept byte");
        end
    endtask

    task automatic transmit_stream();
        logic [7:0] sent [N_BURST];
        logic [7:0] got;
        logic       stop;
        for (int i = 0; i < N_BURST; i++)
            next_byte(sent[i]);
        tx_stalls = 0;
        fork
            begin
                for (int i = 0; i < N_BURST; i++)
                    push_tx(sent[i]);
            end
            begin
                for (int j = 0; j < N_BURST; j++) begin
                    recv_serial(got, stop);
                    check(32'(sent[j]), 32'(got), "txd frame data");
                    check(32'(1), 32'(stop), "txd stop bit");
                end
            end
        join
        check(32'(1), 32'(tx_stalls > 0), "tx_ready low with a full FIFO");
    endtask

    initial begin
        seed      = 32'h9f0a;
        tx_stalls = 0;
        resetn    = 1'b0;
        rxd       = 1'b1;
        rx_ready  = 1'b0;
        tx_beat   = '0;
        tx_valid  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        step();
        reset_values();
        receive_stream();
        frame_error_glitch();
        backpressure_overrun();
        transmit_stream();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb/uart_core_asserts.sv */
/*
 * Concurrent checks on the UART controller, bound to uart_core by the
 * testbench. Covers receive stream stability, the idle level of txd and
 * the sticky overrun flag.
 */
module uart_core_asserts import stream_pkg::*; (
    input logic     clk,
    input logic     resetn,
    input rx_beat_t rx_beat,
    input logic     rx_valid,
    input logic     rx_ready,
    input logic     txd,
    input logic     tx_idle,      // Serializer ready, high only in IDLE.
    input logic     rx_overrun
);

    timeunit 1ns;
    timeprecision 1ps;

    // A pending beat holds until the host takes it.
    rx_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_beat)))
        else $error("rx beat or rx_valid changed before the handshake");

    tx_idle_high: assert property (@(posedge clk) disable iff (!resetn)
        tx_idle |-> txd)
        else $error("txd is low while the transmitter is idle");

    overrun_sticky: assert property (@(posedge clk) disable iff (!resetn)
        rx_overrun |=> rx_overrun)
        else $error("rx_overrun cleared without a reset");

endmodule

/* rtl/uart_core.sv */
/*
 * UART controller top level. Connects the receiver and transmitter to the
 * serial pins and buffers each direction in a byte FIFO toward the host
 * streams. rx_overrun reports bytes lost while every receive buffer was full.
 */
`include "uart_macros.svh"

module uart_core import stream_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     rxd,
    output logic     txd,
    output rx_beat_t rx_beat,
    output logic     rx_valid,
    input  logic     rx_ready,
    input  tx_beat_t tx_beat,
    input  logic     tx_valid,
    output logic     tx_ready,
    output logic     rx_overrun
);

    localparam int RX_W = $bits(rx_beat_t);
    localparam int TX_W = $bits(tx_beat_t);

    rx_beat_t        rx_word;
    logic            rx_word_valid;
    logic            rx_word_ready;
    logic [RX_W-1:0] rx_fifo_din;
    logic [RX_W-1:0] rx_fifo_dout;

    tx_beat_t        tx_word;
    logic            tx_word_valid;
    logic            tx_word_ready;
    logic [TX_W-1:0] tx_fifo_din;
    logic [TX_W-1:0] tx_fifo_dout;

    assign rx_fifo_din = RX_W'(rx_word);
    assign rx_beat     = rx_beat_t'(rx_fifo_dout);
    assign tx_fifo_din = TX_W'(tx_beat);
    assign tx_word     = tx_beat_t'(tx_fifo_dout);

    uart_rx u_rx (
        .clk     (clk),
        .resetn  (resetn),
        .rxd     (rxd),
        .beat    (rx_word),
        .valid   (rx_word_valid),
        .ready   (rx_word_ready),
        .overrun (rx_overrun)
    );

    byte_fifo #(.WIDTH(RX_W), .DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) rx_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .in_data   (rx_fifo_din),
        .in_valid  (rx_word_valid),
        .in_ready  (rx_word_ready),
        .out_data  (rx_fifo_dout),
        .out_valid (rx_valid),
        .out_ready (rx_ready)
    );

    byte_fifo #(.WIDTH(TX_W), .DEPTH_LOG2(`UART_FIFO_DEPTH_LOG2)) tx_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .in_data   (tx_fifo_din),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (tx_fifo_dout),
        .out_valid (tx_word_valid),
        .out_ready (tx_word_ready)
    );

    uart_tx u_tx (
        .clk    (clk),
        .resetn (resetn),
        .beat   (tx_word),
        .valid  (tx_word_valid),
        .ready  (tx_word_ready),
        .txd    (txd)
    );

endmodule

/* rtl/uart_tx.sv */
/*
 * UART transmitter. Takes one beat from its valid/ready input while idle and
 * sends it as a start bit, the data bits LSB first and UART_STOP_BITS stop
 * bits. txd is registered and idles high.
 */
`include "uart_macros.svh"

module uart_tx import serial_pkg::*, stream_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  tx_beat_t beat,
    input  logic     valid,
    output logic     ready,
    output logic     txd
);

    localparam int TW = $clog2(`UART_OVERSAMPLE);
    localparam int DW = `UART_DATA_BITS;
    localparam int CW = $clog2(DW);
    localparam logic [TW-1:0] LAST = TW'(`UART_OVERSAMPLE - 1);
    localparam logic [CW-1:0] LAST_BIT = CW'(DW - 1);
    localparam logic [CW-1:0] LAST_STOP = CW'(`UART_STOP_BITS - 1);

    tx_state_e     state;
    logic [TW-1:0] timer;
    logic [CW-1:0] count;   // Data bit index, then stop bit index.
    logic [DW-1:0] shreg;
    logic          bit_end;

    assign ready   = (state == TX_IDLE);
    assign bit_end = (timer == LAST);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= TX_IDLE;
            timer <= '0;
            count <= '0;
            txd   <= 1'b1;
        end else begin
            timer <= timer + 1'b1;
            unique case (state)
                TX_IDLE: begin
                    timer <= '0;
                    if (valid) begin
                        state <= TX_START;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state <= TX_DATA;
                        count <= '0;
                        txd   <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (count == LAST_BIT) begin
                            state <= TX_STOP;
                            count <= '0;
                            txd   <= 1'b1;
                        end else begin
                            count <= count + 1'b1;
                            txd   <= shreg[1];   // Next bit before the shift lands.
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (count == LAST_STOP)
                            state <= TX_IDLE;
                        else
                            count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready)
            shreg <= beat.data;
        else if (state == TX_DATA && bit_end)
            shreg <= {1'b1, shreg[DW-1:1]};
    end

endmodule

/* rtl/uart_rx.sv */
/*
 * UART receiver. Finds the start bit, confirms it at mid-bit, samples the
 * data bits LSB first and checks one stop bit. The finished byte is held in
 * an output register until the valid/ready handshake; a byte that completes
 * while that register is still full is dropped and sets the sticky overrun
 * flag. rxd is expected to be synchronous to clk already.
 */
`include "uart_macros.svh"

module uart_rx import serial_pkg::*, stream_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     rxd,
    output rx_beat_t beat,
    output logic     valid,
    input  logic     ready,
    output logic     overrun
);

    localparam int TW = $clog2(`UART_OVERSAMPLE);
    localparam int DW = `UART_DATA_BITS;
    localparam int CW = $clog2(DW);
    localparam logic [TW-1:0] HALF = TW'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [TW-1:0] LAST = TW'(`UART_OVERSAMPLE - 1);
    localparam logic [CW-1:0] LAST_BIT = CW'(DW - 1);

    rx_state_e     state;
    logic [TW-1:0] timer;
    logic [CW-1:0] bit_cnt;
    logic [DW-1:0] shreg;
    logic          stop_bit;
    logic          done;
    logic          free;
    logic          sample;

    assign sample = (timer == LAST);
    assign free   = !valid || ready;   // Output register empties this cycle.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= RX_IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done  <= 1'b0;
            timer <= timer + 1'b1;
            unique case (state)
                RX_IDLE: begin
                    timer <= '0;
                    if (!rxd)
                        state <= RX_START;
                end
                RX_START: begin
                    if (timer == HALF) begin
                        timer   <= '0;
                        bit_cnt <= '0;
                        state   <= rxd ? RX_IDLE : RX_DATA;   // High here is a glitch.
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        done  <= 1'b1;
                        state <= rxd ? RX_IDLE : RX_WAIT_IDLE;
                    end
                end
                RX_WAIT_IDLE: begin
                    if (rxd)
                        state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample)
            shreg <= {rxd, shreg[DW-1:1]};   // LSB arrives first.
        if (state == RX_STOP && sample)
            stop_bit <= rxd;
        if (done && free) begin
            beat.data      <= shreg;
            beat.frame_err <= !stop_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid   <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (valid && ready)
                valid <= 1'b0;
            if (done) begin
                if (free)
                    valid <= 1'b1;
                else
                    overrun <= 1'b1;   // Sticky until reset.
            end
        end
    end

endmodule

/* rtl/byte_fifo.sv */
/*
 * Synchronous show-ahead FIFO with valid/ready on both sides.
 * The head entry is visible on out_data whenever out_valid is high. A push
 * and a pop may share a clock. in_ready depends only on the fill level.
 */
module byte_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] FULL = {1'b1, {DEPTH_LOG2{1'b0}}};

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  push;
    logic                  pop;

    assign in_ready  = (count != FULL);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH.
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/stream_pkg.sv */
/*
 * Types for the host stream side of the UART.
 * Each beat travels as a packed struct on a valid/ready stream and is
 * flattened to a bit vector only at the FIFO boundary.
 */
`include "uart_macros.svh"

package stream_pkg;

    // One received byte with its stop bit check.
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       frame_err;   // Stop bit sampled low.
    } rx_beat_t;

    // One byte to transmit.
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
    } tx_beat_t;

endpackage

/* rtl/serial_pkg.sv */
/*
 * Types for the serial line side of the UART.
 * Holds the receiver and transmitter state encodings. The literals carry an
 * RX_ or TX_ prefix so both enums can live in one scope.
 */
package serial_pkg;

    // Receiver FSM. Five states need three bits.
    typedef enum logic [2:0] {
        RX_IDLE      = 3'd0,
        RX_START     = 3'd1,   // Waiting for mid-bit of the start bit.
        RX_DATA      = 3'd2,
        RX_STOP      = 3'd3,
        RX_WAIT_IDLE = 3'd4    // Line stuck low after a bad stop bit.
    } rx_state_e;

    // Transmitter FSM.
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

/* include/uart_macros.svh */
/*
 * Frame format and buffer sizing for the UART controller.
 * The clock runs at UART_OVERSAMPLE times the bit rate, so there is one
 * sample tick per clock and no baud divider. Include this header wherever
 * the frame shape or FIFO depth is needed.
 */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Clock cycles per bit period.
`define UART_OVERSAMPLE 8

// Data bits per frame, sent LSB first.
`define UART_DATA_BITS 8

// Stop bits sent by the transmitter; the receiver checks only one.
`define UART_STOP_BITS 1

// Log2 of the entries in each byte FIFO.
`define UART_FIFO_DEPTH_LOG2 2

`endif
